// ==== common/rf_prot_params.svh ====
// Widths and depth of the protected register file
`ifndef RF_PROT_PARAMS_SVH
`define RF_PROT_PARAMS_SVH

// Stored data word
`define RF_DATA_W  32

// Six Hamming bits plus the overall parity bit
`define RF_CHECK_W 7

// Data bits in the low part, check bits on top
`define RF_CODE_W  39

`define RF_ADDR_W  5

// Words per replica
`define RF_DEPTH   32

`endif

// ==== common/rf_prot_pkg.sv ====
// Shared types of the protected register file
// Vector typedefs, decoder status and the Hamming position map
`include "rf_prot_params.svh"

package rf_prot_pkg;

    typedef logic [`RF_DATA_W-1:0]  rf_data_t;     // Stored data word
    typedef logic [`RF_CHECK_W-1:0] rf_check_t;    // SEC-DED checksum
    typedef logic [`RF_CODE_W-1:0]  rf_code_t;     // {check, data}
    typedef logic [`RF_ADDR_W-1:0]  rf_addr_t;     // Word address

    typedef enum logic [1:0] {
        DEC_OK        = 2'd0,                      // Clean codeword
        DEC_CORRECTED = 2'd1,                      // Single-bit error fixed
        DEC_UNCORR    = 2'd2                       // Double-bit error seen
    } dec_status_t;

    // Hamming position of data bit idx, powers of two are left to the check bits
    function automatic logic [`RF_CHECK_W-2:0] hamming_pos(input int unsigned idx);
        int unsigned            cnt;
        logic [`RF_CHECK_W-2:0] pos;
        cnt = 0;
        pos = '0;
        for (int p = 1; p < 2**(`RF_CHECK_W-1); p++) begin
            if ((p & (p - 1)) != 0) begin
                if (cnt == idx) begin
                    pos = (`RF_CHECK_W-1)'(p);
                end
                cnt++;
            end
        end
        return pos;
    endfunction

endpackage

// ==== logic/secded_encode.sv ====
// SEC-DED check bit generator
// Six Hamming parity bits and one overall parity bit over a data word
`include "rf_prot_params.svh"

module secded_encode (
    input  rf_prot_pkg::rf_data_t  data_i,     // Word to protect
    output rf_prot_pkg::rf_check_t check_o     // Check bits of the word
);
    import rf_prot_pkg::*;

    logic [`RF_CHECK_W-2:0] ham;               // Hamming parity bits

    // Each set data bit toggles the parity bits named by its position
    always_comb begin
        ham = '0;
        for (int k = 0; k < `RF_DATA_W; k++) begin
            if (data_i[k]) begin
                ham = ham ^ hamming_pos(k);
            end
        end
    end

    // Overall parity makes the whole codeword even
    assign check_o = {(^data_i) ^ (^ham), ham};

endmodule

// ==== logic/secded_decode.sv ====
// SEC-DED decoder
// Syndrome from recomputed check bits, single-bit correction and
// double-bit detection
`include "rf_prot_params.svh"

module secded_decode (
    input  rf_prot_pkg::rf_code_t    code_i,      // Stored codeword
    output rf_prot_pkg::rf_data_t    data_o,      // Corrected data
    output rf_prot_pkg::dec_status_t status_o     // Decode result
);
    import rf_prot_pkg::*;

    rf_data_t               data_rx;
    rf_check_t              check_rx;
    rf_check_t              check_calc;
    logic [`RF_CHECK_W-1:0] syndrome;             // Overall parity error on top
    rf_data_t               flip_mask;            // Data bit named by the syndrome

    assign data_rx  = code_i[`RF_DATA_W-1:0];
    assign check_rx = code_i[`RF_CODE_W-1:`RF_DATA_W];

    secded_encode m_enc (
        .data_i  (data_rx),
        .check_o (check_calc)
    );

    assign syndrome[`RF_CHECK_W-2:0] = check_calc[`RF_CHECK_W-2:0] ^ check_rx[`RF_CHECK_W-2:0];
    assign syndrome[`RF_CHECK_W-1]   = ^code_i;   // Odd when an odd number of bits flipped

    always_comb begin
        for (int k = 0; k < `RF_DATA_W; k++) begin
            flip_mask[k] = (hamming_pos(k) == syndrome[`RF_CHECK_W-2:0]);
        end
    end

    always_comb begin
        data_o   = data_rx;
        status_o = DEC_OK;
        if (syndrome != '0) begin
            if (!syndrome[`RF_CHECK_W-1]) begin
                status_o = DEC_UNCORR;                 // Even parity, two bits flipped
            end else if (syndrome[`RF_CHECK_W-2:0] < `RF_CODE_W) begin
                data_o   = data_rx ^ flip_mask;        // No data bit hit for check bit errors
                status_o = DEC_CORRECTED;
            end else begin
                // Position outside the codeword, so more than one bit is wrong
                status_o = DEC_UNCORR;
            end
        end
    end

endmodule

// ==== rf_bank/rf_bank.sv ====
// One replica of the register file
// Codeword array with a single write port and a registered read port
`include "rf_prot_params.svh"

module rf_bank (
    input  logic                  s_clk_i,
    input  logic                  rst_n_i,     // Synchronous, active low
    input  logic                  we_i,        // Write enable
    input  logic                  re_i,        // Read enable
    input  rf_prot_pkg::rf_addr_t addr_i,      // Word address
    input  rf_prot_pkg::rf_code_t wcode_i,     // Codeword to store
    output rf_prot_pkg::rf_code_t rcode_o      // Codeword read last cycle
);
    import rf_prot_pkg::*;

    rf_code_t mem [`RF_DEPTH];

    // All-zero is a valid codeword, so a cleared bank decodes clean
    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RF_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[addr_i] <= wcode_i;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            rcode_o <= '0;
        end else if (re_i) begin
            rcode_o <= mem[addr_i];              // Held until the next read
        end
    end

endmodule

// ==== rf_bank/rf_replica_voter.sv ====
// Voter over the two decoded replicas
// Picks the result word, raises the error flags and requests scrubbing
`include "rf_prot_params.svh"

module rf_replica_voter (
    input  rf_prot_pkg::rf_data_t    data_a_i,
    input  rf_prot_pkg::rf_data_t    data_b_i,
    input  rf_prot_pkg::dec_status_t status_a_i,
    input  rf_prot_pkg::dec_status_t status_b_i,
    output rf_prot_pkg::rf_data_t    rdata_o,       // Voted word
    output logic                     corr_o,        // Error seen and repaired
    output logic                     unrec_o,       // No trustworthy word
    output logic                     scrub_a_o,     // Rewrite replica A
    output logic                     scrub_b_o,     // Rewrite replica B
    output rf_prot_pkg::rf_code_t    scrub_code_o   // Repaired codeword
);
    import rf_prot_pkg::*;

    logic      usable_a;
    logic      usable_b;
    rf_check_t scrub_check;

    assign usable_a = (status_a_i != DEC_UNCORR);
    assign usable_b = (status_b_i != DEC_UNCORR);

    assign rdata_o = usable_a ? data_a_i : data_b_i;     // A has priority

    // Two usable replicas that disagree cannot be trusted either
    assign unrec_o = (!usable_a && !usable_b) ||
                     (usable_a && usable_b && (data_a_i != data_b_i));

    assign corr_o = !unrec_o && ((status_a_i != DEC_OK) || (status_b_i != DEC_OK));

    assign scrub_a_o = !unrec_o && (status_a_i != DEC_OK);
    assign scrub_b_o = !unrec_o && (status_b_i != DEC_OK);

    secded_encode m_scrub_enc (
        .data_i  (rdata_o),
        .check_o (scrub_check)
    );

    assign scrub_code_o = {scrub_check, rdata_o};

endmodule

// ==== logic/rf_access_ctrl.sv ====
// Request sequencer of the protected register file
// Four-phase req/ack FSM, write encoding with error injection,
// result latching and scrub write-back
`include "rf_prot_params.svh"

module rf_access_ctrl (
    input  logic                  s_clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_i,           // Request, held until ack
    input  logic                  we_i,            // Write when high, read when low
    input  rf_prot_pkg::rf_addr_t addr_i,
    input  rf_prot_pkg::rf_data_t wdata_i,
    input  rf_prot_pkg::rf_code_t inj_a_mask_i,    // Bits to flip in replica A
    input  rf_prot_pkg::rf_code_t inj_b_mask_i,    // Bits to flip in replica B
    output logic                  ack_o,
    output rf_prot_pkg::rf_data_t rdata_o,
    output logic                  corr_o,
    output logic                  unrec_o,
    input  rf_prot_pkg::rf_data_t v_rdata_i,       // Voter result
    input  logic                  v_corr_i,
    input  logic                  v_unrec_i,
    input  logic                  scrub_a_i,
    input  logic                  scrub_b_i,
    input  rf_prot_pkg::rf_code_t scrub_code_i,
    output logic                  bank_we_a_o,
    output logic                  bank_we_b_o,
    output logic                  bank_re_o,
    output rf_prot_pkg::rf_addr_t bank_addr_o,
    output rf_prot_pkg::rf_code_t bank_wcode_a_o,
    output rf_prot_pkg::rf_code_t bank_wcode_b_o
);
    import rf_prot_pkg::*;

    typedef enum logic [1:0] {
        IDLE,       // Waiting for req_i
        ACCESS,     // Write done, or read issued to the banks
        RESULT,     // Voter output valid from the registered codewords
        ACK         // Result held until req_i drops
    } ctrl_state_t;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        accept;
    logic        scrub_en;
    logic        we_q;
    rf_addr_t    addr_q;
    rf_check_t   wcheck;
    rf_code_t    wcode;
    rf_data_t    rdata_q;
    logic        corr_q;
    logic        unrec_q;

    assign accept   = (state_q == IDLE) && req_i;
    assign scrub_en = (state_q == RESULT) && !we_q;  // Write-back on the edge into ACK

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (req_i) state_d = ACCESS;
            ACCESS:  state_d = RESULT;
            RESULT:  state_d = ACK;
            ACK:     if (!req_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            we_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                we_q <= we_i;
            end
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (accept) begin
            addr_q <= addr_i;
        end
    end

    // Write data is encoded once, each replica gets its own mask
    secded_encode m_wr_enc (
        .data_i  (wdata_i),
        .check_o (wcheck)
    );

    assign wcode = {wcheck, wdata_i};

    assign bank_we_a_o    = (accept && we_i) || (scrub_en && scrub_a_i);
    assign bank_we_b_o    = (accept && we_i) || (scrub_en && scrub_b_i);
    assign bank_re_o      = (state_q == ACCESS) && !we_q;
    assign bank_addr_o    = (state_q == IDLE) ? addr_i : addr_q;
    assign bank_wcode_a_o = (state_q == IDLE) ? (wcode ^ inj_a_mask_i) : scrub_code_i;
    assign bank_wcode_b_o = (state_q == IDLE) ? (wcode ^ inj_b_mask_i) : scrub_code_i;

    // Flags follow the last read, a write clears them
    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            corr_q  <= 1'b0;
            unrec_q <= 1'b0;
        end else if (state_q == RESULT) begin
            corr_q  <= !we_q && v_corr_i;
            unrec_q <= !we_q && v_unrec_i;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (scrub_en) begin
            rdata_q <= v_rdata_i;    // Stays put while the scrub rewrites the bank
        end
    end

    assign ack_o   = (state_q == ACK);
    assign rdata_o = rdata_q;
    assign corr_o  = corr_q;
    assign unrec_o = unrec_q;

endmodule

// ==== logic/rf_prot_top.sv ====
// Top level of the protected register file
// Controller, two replica banks with their decoders and the voter

module rf_prot_top (
    input  logic                  s_clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_i,
    input  logic                  we_i,
    input  rf_prot_pkg::rf_addr_t addr_i,
    input  rf_prot_pkg::rf_data_t wdata_i,
    input  rf_prot_pkg::rf_code_t inj_a_mask_i,
    input  rf_prot_pkg::rf_code_t inj_b_mask_i,
    output logic                  ack_o,
    output rf_prot_pkg::rf_data_t rdata_o,
    output logic                  corr_o,
    output logic                  unrec_o
);

    logic                     bank_we_a;
    logic                     bank_we_b;
    logic                     bank_re;
    rf_prot_pkg::rf_addr_t    bank_addr;
    rf_prot_pkg::rf_code_t    wcode_a;
    rf_prot_pkg::rf_code_t    wcode_b;
    rf_prot_pkg::rf_code_t    rcode_a;
    rf_prot_pkg::rf_code_t    rcode_b;
    rf_prot_pkg::rf_data_t    dec_data_a;
    rf_prot_pkg::rf_data_t    dec_data_b;
    rf_prot_pkg::dec_status_t dec_status_a;
    rf_prot_pkg::dec_status_t dec_status_b;
    rf_prot_pkg::rf_data_t    v_rdata;
    logic                     v_corr;
    logic                     v_unrec;
    logic                     scrub_a;
    logic                     scrub_b;
    rf_prot_pkg::rf_code_t    scrub_code;

    rf_access_ctrl m_ctrl (
        .s_clk_i        (s_clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .we_i           (we_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .inj_a_mask_i   (inj_a_mask_i),
        .inj_b_mask_i   (inj_b_mask_i),
        .ack_o          (ack_o),
        .rdata_o        (rdata_o),
        .corr_o         (corr_o),
        .unrec_o        (unrec_o),
        .v_rdata_i      (v_rdata),
        .v_corr_i       (v_corr),
        .v_unrec_i      (v_unrec),
        .scrub_a_i      (scrub_a),
        .scrub_b_i      (scrub_b),
        .scrub_code_i   (scrub_code),
        .bank_we_a_o    (bank_we_a),
        .bank_we_b_o    (bank_we_b),
        .bank_re_o      (bank_re),
        .bank_addr_o    (bank_addr),
        .bank_wcode_a_o (wcode_a),
        .bank_wcode_b_o (wcode_b)
    );

    rf_bank m_bank_a (
        .s_clk_i (s_clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (bank_we_a),
        .re_i    (bank_re),
        .addr_i  (bank_addr),
        .wcode_i (wcode_a),
        .rcode_o (rcode_a)
    );

    rf_bank m_bank_b (
        .s_clk_i (s_clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (bank_we_b),
        .re_i    (bank_re),
        .addr_i  (bank_addr),
        .wcode_i (wcode_b),
        .rcode_o (rcode_b)
    );

    secded_decode m_dec_a (
        .code_i   (rcode_a),
        .data_o   (dec_data_a),
        .status_o (dec_status_a)
    );

    secded_decode m_dec_b (
        .code_i   (rcode_b),
        .data_o   (dec_data_b),
        .status_o (dec_status_b)
    );

    rf_replica_voter m_voter (
        .data_a_i     (dec_data_a),
        .data_b_i     (dec_data_b),
        .status_a_i   (dec_status_a),
        .status_b_i   (dec_status_b),
        .rdata_o      (v_rdata),
        .corr_o       (v_corr),
        .unrec_o      (v_unrec),
        .scrub_a_o    (scrub_a),
        .scrub_b_o    (scrub_b),
        .scrub_code_o (scrub_code)
    );

endmodule

// ==== tests/rf_ref_model.svh ====
// Reference model of the protected register file
// Expected word and flipped-bit count per replica for every address,
// decoder status per replica and the voter and scrub rule built on it
`ifndef RF_REF_MODEL_SVH
`define RF_REF_MODEL_SVH

rf_data_t    exp_mem [`RF_DEPTH];     // Last written word
int unsigned flips_a [`RF_DEPTH];     // Bits flipped in replica A
int unsigned flips_b [`RF_DEPTH];     // Bits flipped in replica B

task automatic clear_expected();
    for (int i = 0; i < `RF_DEPTH; i++) begin
        exp_mem[i] = '0;              // Banks clear to the zero codeword
        flips_a[i] = 0;
        flips_b[i] = 0;
    end
endtask

function automatic int unsigned count_bits(input rf_code_t v);
    int unsigned n;
    n = 0;
    for (int i = 0; i < `RF_CODE_W; i++) begin
        n += v[i];
    end
    return n;
endfunction

function automatic dec_status_t status_for_flips(input int unsigned n);
    if (n == 0) begin
        return DEC_OK;
    end else if (n == 1) begin
        return DEC_CORRECTED;
    end
    return DEC_UNCORR;
endfunction

task automatic record_write(input rf_addr_t at_addr, input rf_data_t data,
                            input rf_code_t mask_a, input rf_code_t mask_b);
    exp_mem[at_addr] = data;
    flips_a[at_addr] = count_bits(mask_a);
    flips_b[at_addr] = count_bits(mask_b);
endtask

// A usable replica always decodes to the written word, so the two can only
// disagree when neither is usable
task automatic predict_read(input rf_addr_t at_addr, output rf_data_t data,
                            output logic corr, output logic unrec);
    dec_status_t sa;
    dec_status_t sb;
    sa    = status_for_flips(flips_a[at_addr]);
    sb    = status_for_flips(flips_b[at_addr]);
    unrec = (sa == DEC_UNCORR) && (sb == DEC_UNCORR);
    corr  = !unrec && ((sa != DEC_OK) || (sb != DEC_OK));
    data  = exp_mem[at_addr];
    if (!unrec) begin
        flips_a[at_addr] = 0;         // Scrub rewrites the failing replicas
        flips_b[at_addr] = 0;
    end
endtask

`endif

// ==== tests/tb_rf_prot.sv ====
// Testbench of the protected register file
// Random reads and writes with error injection, four-phase handshake
// driver, model based checks and a run summary
`include "rf_prot_params.svh"

module tb_rf_prot;
    timeunit 1ns;
    timeprecision 1ps;

    import rf_prot_pkg::*;

    localparam int XACT_TOTAL     = 108;              // Transactions over all tests
    localparam int TIMEOUT_CYCLES = 10 * XACT_TOTAL * 6;
    localparam int ACK_WAIT_MAX   = 16;

    logic     clk;
    logic     rst_n;
    logic     req;
    logic     we;
    rf_addr_t addr;
    rf_data_t wdata;
    rf_code_t inj_a_mask;
    rf_code_t inj_b_mask;
    logic     ack;
    rf_data_t rdata;
    logic     corr;
    logic     unrec;

    integer   seed;
    int       err_cnt;
    int       check_cnt;
    int       xact_cnt;
    int       cycle_cnt;
    int       errs_mark;
    rf_addr_t pick_addr;
    rf_data_t pick_data;

    `include "rf_ref_model.svh"

    rf_prot_top dut_i (
        .s_clk_i      (clk),
        .rst_n_i      (rst_n),
        .req_i        (req),
        .we_i         (we),
        .addr_i       (addr),
        .wdata_i      (wdata),
        .inj_a_mask_i (inj_a_mask),
        .inj_b_mask_i (inj_b_mask),
        .ack_o        (ack),
        .rdata_o      (rdata),
        .corr_o       (corr),
        .unrec_o      (unrec)
    );

    always #4 clk = ~clk;                             // 8 ns period

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Errors found");
            $finish;
        end
    end

    task automatic compare_val(input logic [63:0] got, input logic [63:0] exp,
                               input string msg);
        check_cnt++;
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
            err_cnt++;
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Set random distinct bits until the mask has nbits of them
    function automatic rf_code_t make_mask(input int nbits);
        rf_code_t m;
        m = '0;
        while (count_bits(m) < nbits) begin
            m[rand_below(`RF_CODE_W)] = 1'b1;
        end
        return m;
    endfunction

    // One four-phase transaction that starts and ends 1 ns after a rising edge
    task automatic run_xact(input logic is_write, input rf_addr_t at_addr,
                            input rf_data_t data, input rf_code_t mask_a,
                            input rf_code_t mask_b, input int hold,
                            output rf_data_t got_data, output logic got_corr,
                            output logic got_unrec);
        int waited;
        we         = is_write;
        addr       = at_addr;
        wdata      = data;
        inj_a_mask = mask_a;
        inj_b_mask = mask_b;
        req        = 1'b1;
        xact_cnt++;
        @(posedge clk);                               // Edge that samples req
        #1;
        waited = 0;
        while (!ack && waited < ACK_WAIT_MAX) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!ack) begin
            $display("Handshake failure at %0t: ack_o never rose for address %0d",
                     $time, at_addr);
            err_cnt++;
        end else begin
            compare_val(waited, 2, "ack_o latency after req_i sampled");
        end
        got_data  = rdata;
        got_corr  = corr;
        got_unrec = unrec;
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            #1;
            compare_val(ack, 1'b1, "ack_o held while req_i high");
            compare_val(rdata, got_data, "rdata_o held while req_i high");
            compare_val({corr, unrec}, {got_corr, got_unrec}, "flags held while req_i high");
        end
        req = 1'b0;
        #6;                                           // Just before the edge that samples it
        compare_val(ack, 1'b1, "ack_o held until req_i low is sampled");
        @(posedge clk);
        #1;
        if (ack !== 1'b0) begin
            $display("Handshake failure at %0t: ack_o still high after req_i dropped",
                     $time);
            err_cnt++;
        end
    endtask

    task automatic write_word(input rf_addr_t at_addr, input rf_data_t data,
                              input rf_code_t mask_a, input rf_code_t mask_b,
                              input int hold);
        rf_data_t d;
        logic     c;
        logic     u;
        run_xact(1'b1, at_addr, data, mask_a, mask_b, hold, d, c, u);
        record_write(at_addr, data, mask_a, mask_b);
    endtask

    task automatic read_check(input rf_addr_t at_addr, input int hold);
        rf_data_t got_d;
        logic     got_c;
        logic     got_u;
        rf_data_t exp_d;
        logic     exp_c;
        logic     exp_u;
        run_xact(1'b0, at_addr, '0, '0, '0, hold, got_d, got_c, got_u);
        predict_read(at_addr, exp_d, exp_c, exp_u);
        compare_val(got_u, exp_u, $sformatf("unrec_o at address %0d", at_addr));
        compare_val(got_c, exp_c, $sformatf("corr_o at address %0d", at_addr));
        if (!exp_u) begin
            compare_val(got_d, exp_d, $sformatf("rdata_o at address %0d", at_addr));
        end
    endtask

    task automatic test_done(input string name, input int errs_before);
        $display("Test %-24s %s (%0d new errors)", name,
                 (err_cnt == errs_before) ? "passed" : "FAILED", err_cnt - errs_before);
    endtask

    initial begin
        seed       = 24914;
        clk        = 1'b0;
        rst_n      = 1'b0;
        req        = 1'b0;
        we         = 1'b0;
        addr       = '0;
        wdata      = '0;
        inj_a_mask = '0;
        inj_b_mask = '0;
        err_cnt    = 0;
        check_cnt  = 0;
        xact_cnt   = 0;
        cycle_cnt  = 0;
        clear_expected();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        errs_mark = err_cnt;
        for (int i = 0; i < 8; i++) begin
            read_check(rf_addr_t'(rand_below(`RF_DEPTH)), 0);
        end
        test_done("reset contents", errs_mark);

        errs_mark = err_cnt;
        for (int i = 0; i < 16; i++) begin
            pick_addr = rf_addr_t'(rand_below(`RF_DEPTH));
            write_word(pick_addr, $random(seed), '0, '0, 0);
            read_check(pick_addr, 0);
        end
        test_done("clean write and read", errs_mark);

        errs_mark = err_cnt;
        for (int i = 0; i < 8; i++) begin
            pick_addr = rf_addr_t'(rand_below(`RF_DEPTH));
            pick_data = $random(seed);
            if (rand_below(2) == 0) begin
                write_word(pick_addr, pick_data, make_mask(1), '0, 0);
            end else begin
                write_word(pick_addr, pick_data, '0, make_mask(1), 0);
            end
            read_check(pick_addr, 0);             // Corrected and scrubbed
            read_check(pick_addr, 0);
        end
        test_done("single-bit injection", errs_mark);

        errs_mark = err_cnt;
        for (int i = 0; i < 8; i++) begin
            pick_addr = rf_addr_t'(rand_below(`RF_DEPTH));
            pick_data = $random(seed);
            if (rand_below(2) == 0) begin
                write_word(pick_addr, pick_data, make_mask(2), '0, 0);
            end else begin
                write_word(pick_addr, pick_data, '0, make_mask(2), 0);
            end
            read_check(pick_addr, 0);
            read_check(pick_addr, 0);
        end
        test_done("double-bit in one replica", errs_mark);

        errs_mark = err_cnt;
        for (int i = 0; i < 4; i++) begin
            pick_addr = rf_addr_t'(rand_below(`RF_DEPTH));
            write_word(pick_addr, $random(seed), make_mask(2), make_mask(2), 0);
            read_check(pick_addr, 0);
            read_check(pick_addr, 0);             // Still lost as nothing was scrubbed
        end
        test_done("double-bit in both", errs_mark);

        errs_mark = err_cnt;
        for (int i = 0; i < 4; i++) begin
            pick_addr = rf_addr_t'(rand_below(`RF_DEPTH));
            write_word(pick_addr, $random(seed), '0, '0, rand_below(6));
            read_check(pick_addr, rand_below(6));
        end
        test_done("handshake hold", errs_mark);

        $display("Summary: %0d transactions, %0d checks, %0d errors",
                 xact_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+common
+incdir+tests
common/rf_prot_pkg.sv
logic/secded_encode.sv
logic/secded_decode.sv
rf_bank/rf_bank.sv
rf_bank/rf_replica_voter.sv
logic/rf_access_ctrl.sv
logic/rf_prot_top.sv
tests/tb_rf_prot.sv

// ==== Bender.yml ====
package:
  name: rf_prot

sources:
  - include_dirs:
      - common
    files:
      - common/rf_prot_pkg.sv
      - logic/secded_encode.sv
      - logic/secded_decode.sv
      - rf_bank/rf_bank.sv
      - rf_bank/rf_replica_voter.sv
      - logic/rf_access_ctrl.sv
      - logic/rf_prot_top.sv
  - target: test
    include_dirs:
      - common
      - tests
    files:
      - tests/tb_rf_prot.sv
